//--- pingPongPkg.sv
// ping pong test shared types

package pingPongPkg;

   // **************************************************
   // widths and constants
   // **************************************************
   localparam int addrBits    = 20;   // cache-line address
   localparam int lineBits    = 512;  // one cache line
   localparam int tagBits     = 16;   // msb set marks a read
   localparam int countBits   = 21;   // line counters
   localparam int seqAddrBits = 17;   // low payload bits carrying the address
   localparam int flagOnes    = 64;   // ones in the flag line
   localparam int pollWordLsb = 32;   // flag word checked by the poll
   localparam int uMsgHintBit = 15;   // header bit, hint message

   localparam logic [31:0] fillWord = 32'h0000_0001;
   localparam logic [2:0]  uMsgId   = 3'd0;           // expected message id

   // derived line images
   localparam logic [lineBits-1:0] fillLine = {(lineBits/32){fillWord}};
   localparam logic [lineBits-1:0] flagLine =
      {{(lineBits-flagOnes){1'b0}}, {flagOnes{1'b1}}};

   // **************************************************
   // state and mode encodings
   // **************************************************
   typedef enum logic [2:0] {WR_WAIT, WR_WRITE, WR_FENCE, WR_FLAG, WR_DONE} wrState_t;
   typedef enum logic [1:0] {RD_WAIT, RD_READ, RD_RESP, RD_DONE} rdState_t;
   typedef enum logic [1:0] {POLL_WAIT, POLL_READ, POLL_RESP, POLL_DONE} pollState_t;

   // host to fpga notification method
   typedef enum logic [1:0] {
      MODE_POLL      = 2'd0,   // poll the flag line
      MODE_CSR       = 2'd1,   // csr write pulse
      MODE_UMSG_DATA = 2'd2,   // message with data
      MODE_UMSG_HINT = 2'd3    // message hint only
   } notifyMode_t;

   // **************************************************
   // port bundles
   // **************************************************
   typedef struct packed {
      logic              go;         // one-cycle start
      logic [31:0]       numLines;
      notifyMode_t       mode;
   } testCfg_t;

   typedef struct packed {
      logic                en;
      logic                fence;
      logic [addrBits-1:0] addr;
      logic [tagBits-1:0]  tag;
      logic [lineBits-1:0] data;
   } wrReq_t;

   typedef struct packed {
      logic                en;
      logic [addrBits-1:0] addr;
      logic [tagBits-1:0]  tag;
   } rdReq_t;

   typedef struct packed {
      logic                valid;
      logic [15:0]         hdr;      // also message header
      logic [addrBits-1:0] addr;
      logic [lineBits-1:0] data;
   } rdRsp_t;

   typedef struct packed {
      logic [15:0]          data16;   // low data bits of failing line
      logic [15:0]          addr16;
      logic [15:0]          hdr16;
      logic [countBits-1:0] count;    // responses seen before it
   } errInfo_t;

endpackage

//--- writeSequencer.sv
// payload, fence and flag writer
`timescale 1ns/100ps

module writeSequencer (
   input  logic                  Clk_400,
   input  logic                  rstN,
   input  pingPongPkg::testCfg_t cfg,
   input  logic                  wrSent,   // current request taken
   output pingPongPkg::wrReq_t   wrReq,
   output logic                  wrDone    // level, flag line taken
);
   import pingPongPkg::*;

   wrState_t             wrState;
   logic [addrBits-1:0]  wrAddr;      // address of pending request
   logic [countBits-1:0] wrCount;     // payload lines, counts from 1
   logic [countBits-1:0] lineLimit;

   assign lineLimit = cfg.numLines[countBits-1:0];
   assign wrDone    = (wrState == WR_DONE);

   // **************************************************
   // request decode
   // **************************************************
   always_comb
   begin
      wrReq.en    = (wrState == WR_WRITE) || (wrState == WR_FLAG);
      wrReq.fence = (wrState == WR_FENCE);    // fence goes out alone
      wrReq.addr  = wrAddr;
      wrReq.tag   = {1'b0, wrAddr[tagBits-2:0]};   // write marker
      if (wrState == WR_FLAG)
         wrReq.data = flagLine;
      else
         // every word 1, low bits overlaid with the line address
         wrReq.data = {fillLine[lineBits-1:seqAddrBits], wrAddr[seqAddrBits-1:0]};
   end

   // **************************************************
   // write fsm
   // **************************************************
   always_ff @(posedge Clk_400 or negedge rstN)
   begin
      if (!rstN)
      begin
         wrState <= WR_WAIT;
         wrAddr  <= '0;
         wrCount <= '0;
      end
      else
      begin
         case (wrState)
            WR_WAIT:
            begin
               wrAddr  <= '0;
               wrCount <= countBits'(1);
               if (cfg.go)
               begin
                  if (cfg.numLines != 32'd0)
                     wrState <= WR_WRITE;
                  else
                     wrState <= WR_FLAG;     // flag only, at address 0
               end
            end
            WR_WRITE:
            begin
               if (wrSent)
               begin
                  wrAddr  <= wrAddr + addrBits'(1);   // ends at N, the flag slot
                  wrCount <= wrCount + countBits'(1);
                  if (wrCount == lineLimit)
                     wrState <= WR_FENCE;
               end
            end
            WR_FENCE:
               if (wrSent)
                  wrState <= WR_FLAG;
            WR_FLAG:
               if (wrSent)
                  wrState <= WR_DONE;
            default:
               wrState <= WR_DONE;           // parked until reset
         endcase
      end
   end

   // pending request must hold its shape until taken
   aWrHold : assert property (@(posedge Clk_400) disable iff (!rstN)
      (wrReq.en || wrReq.fence) && !wrSent
         |=> $stable(wrReq.en) && $stable(wrReq.fence) && $stable(wrReq.addr))
      else $error("write request changed before wrSent");

endmodule

//--- notifyDetect.sv
// host notification detector
`timescale 1ns/100ps

module notifyDetect (
   input  logic                  Clk_400,
   input  logic                  rstN,
   input  pingPongPkg::testCfg_t cfg,
   input  logic                  wrDone,
   input  pingPongPkg::rdRsp_t   rdRsp,     // flag data or message header
   input  logic                  uMsgValid,
   input  logic                  csrWrite,
   output pingPongPkg::rdReq_t   pollReq,
   input  logic                  rdSent,
   output logic                  rdGo       // one-cycle start of readback
);
   import pingPongPkg::*;

   pollState_t          pollState;
   logic [addrBits-1:0] flagAddr;    // flag line sits right after payload
   logic                pollHit;     // flag word seen all ones
   logic                idOk;        // message id matches
   logic                goNext;

   assign flagAddr = cfg.numLines[addrBits-1:0];

   // poll read request
   assign pollReq.en   = (pollState == POLL_READ);
   assign pollReq.addr = flagAddr;
   assign pollReq.tag  = {1'b1, flagAddr[tagBits-2:0]};

   assign pollHit = (pollState == POLL_RESP) && rdRsp.valid
                    && (rdRsp.data[pollWordLsb +: 32] == 32'hffff_ffff);
   assign idOk    = (rdRsp.hdr[2:0] == uMsgId);

   // **************************************************
   // method select
   // **************************************************
   always_comb
   begin
      case (cfg.mode)
         MODE_POLL:      goNext = pollHit;
         MODE_CSR:       goNext = csrWrite;
         MODE_UMSG_DATA: goNext = uMsgValid && !rdRsp.hdr[uMsgHintBit] && idOk;
         default:        goNext = uMsgValid && rdRsp.hdr[uMsgHintBit] && idOk;
      endcase
   end

   // poll fsm, reissues the read until the flag lands
   always_ff @(posedge Clk_400 or negedge rstN)
   begin
      if (!rstN)
      begin
         pollState <= POLL_WAIT;
         rdGo      <= 1'b0;
      end
      else
      begin
         rdGo <= goNext;
         case (pollState)
            POLL_WAIT:
               if (wrDone && (cfg.mode == MODE_POLL))
                  pollState <= POLL_READ;
            POLL_READ:
               if (rdSent)
                  pollState <= POLL_RESP;
            POLL_RESP:
            begin
               if (rdRsp.valid)
                  pollState <= pollHit ? POLL_DONE : POLL_READ;   // stale flag, retry
            end
            default:
               pollState <= POLL_DONE;
         endcase
      end
   end

   aGoPulse : assert property (@(posedge Clk_400) disable iff (!rstN)
      rdGo |=> !rdGo)
      else $error("rdGo held longer than one cycle");

endmodule

//--- readSequencer.sv
// readback sequencer and data checker
`timescale 1ns/100ps

module readSequencer (
   input  logic                   Clk_400,
   input  logic                   rstN,
   input  pingPongPkg::testCfg_t  cfg,
   input  logic                   rdGo,
   input  pingPongPkg::rdReq_t    pollReq,    // forwarded while idle
   input  logic                   rdSent,
   input  pingPongPkg::rdRsp_t    rdRsp,
   output pingPongPkg::rdReq_t    rdReq,
   output logic                   rdDone,
   output logic                   errorValid, // sticky
   output pingPongPkg::errInfo_t  errorInfo
);
   import pingPongPkg::*;

   rdState_t             rdState;
   logic [addrBits-1:0]  rdAddr;
   logic [countBits-1:0] reqCount;    // counts from 1
   logic [countBits-1:0] rspCount;
   logic [countBits-1:0] lineLimit;
   logic                 inRead;      // payload reads in flight

   // response pipe, first stage
   logic                 rspValidQ;
   logic [15:0]          rspDataQ;
   logic [15:0]          rspAddrQ;
   logic [15:0]          rspHdrQ;
   logic [countBits-1:0] rspCountQ;

   assign lineLimit = cfg.numLines[countBits-1:0];
   assign inRead    = (rdState == RD_READ) || (rdState == RD_RESP);
   assign rdDone    = (rdState == RD_DONE);

   // **************************************************
   // read port mux
   // **************************************************
   always_comb
   begin
      if (rdState == RD_WAIT)
         rdReq = pollReq;
      else
      begin
         rdReq.en   = (rdState == RD_READ);
         rdReq.addr = rdAddr;
         rdReq.tag  = {1'b1, rdAddr[tagBits-2:0]};   // read marker
      end
   end

   // **************************************************
   // read fsm and counters
   // **************************************************
   always_ff @(posedge Clk_400 or negedge rstN)
   begin
      if (!rstN)
      begin
         rdState  <= RD_WAIT;
         rdAddr   <= '0;
         reqCount <= '0;
         rspCount <= '0;
      end
      else
      begin
         case (rdState)
            RD_WAIT:
            begin
               rdAddr   <= '0;
               reqCount <= countBits'(1);
               rspCount <= '0;
               if (rdGo)
                  rdState <= (cfg.numLines != 32'd0) ? RD_READ : RD_DONE;
            end
            RD_READ:
            begin
               if (rdSent)
               begin
                  rdAddr   <= rdAddr + addrBits'(1);
                  reqCount <= reqCount + countBits'(1);
                  if (reqCount == lineLimit)
                     rdState <= RD_RESP;   // last read issued
               end
            end
            RD_RESP:
               if (rspCount == lineLimit)
                  rdState <= RD_DONE;
            default:
               rdState <= RD_DONE;
         endcase

         // responses come back in any order, only count them
         if (rdRsp.valid && inRead)
            rspCount <= rspCount + countBits'(1);
      end
   end

   // **************************************************
   // data check, two cycles behind the response
   // **************************************************
   always_ff @(posedge Clk_400 or negedge rstN)
   begin
      if (!rstN)
      begin
         rspValidQ  <= 1'b0;
         errorValid <= 1'b0;
      end
      else
      begin
         rspValidQ <= rdRsp.valid && inRead;     // poll responses excluded
         if (rspValidQ && (rspDataQ != rspAddrQ))
            errorValid <= 1'b1;
      end
   end

   always_ff @(posedge Clk_400)
   begin
      rspDataQ  <= rdRsp.data[15:0];
      rspAddrQ  <= rdRsp.addr[15:0];
      rspHdrQ   <= rdRsp.hdr;
      rspCountQ <= rspCount;
      errorInfo <= '{data16: rspDataQ, addr16: rspAddrQ, hdr16: rspHdrQ, count: rspCountQ};
   end

   // host must not return more lines than were requested
   aRspBound : assert property (@(posedge Clk_400) disable iff (!rstN)
      inRead |-> (rspCount <= lineLimit))
      else $error("more read responses than numLines");

endmodule

//--- pingPongTest.sv
// notification latency test top
`timescale 1ns/100ps

module pingPongTest (
   input  logic                   Clk_400,
   input  logic                   rstN,
   input  pingPongPkg::testCfg_t  cfg,
   output pingPongPkg::wrReq_t    wrReq,
   input  logic                   wrSent,      // host took write or fence
   output pingPongPkg::rdReq_t    rdReq,
   input  logic                   rdSent,      // host took read
   input  pingPongPkg::rdRsp_t    rdRsp,
   input  logic                   uMsgValid,
   input  logic                   csrWrite,
   output logic                   testCmp,
   output logic                   errorValid,
   output pingPongPkg::errInfo_t  errorInfo
);
   import pingPongPkg::*;

   logic   wrDone;    // flag line accepted
   logic   rdDone;    // all read responses back
   logic   rdGo;      // host notification seen
   rdReq_t pollReq;   // flag poll, muxed onto read port

   // **************************************************
   // fpga to host side
   // **************************************************
   writeSequencer uWrSeq (
      .Clk_400 (Clk_400),
      .rstN    (rstN),
      .cfg     (cfg),
      .wrSent  (wrSent),
      .wrReq   (wrReq),
      .wrDone  (wrDone)
   );

   // host to fpga notification
   notifyDetect uNotify (
      .Clk_400   (Clk_400),
      .rstN      (rstN),
      .cfg       (cfg),
      .wrDone    (wrDone),
      .rdRsp     (rdRsp),
      .uMsgValid (uMsgValid),
      .csrWrite  (csrWrite),
      .pollReq   (pollReq),
      .rdSent    (rdSent),
      .rdGo      (rdGo)
   );

   // readback and data check, owns the read port
   readSequencer uRdSeq (
      .Clk_400    (Clk_400),
      .rstN       (rstN),
      .cfg        (cfg),
      .rdGo       (rdGo),
      .pollReq    (pollReq),
      .rdSent     (rdSent),
      .rdRsp      (rdRsp),
      .rdReq      (rdReq),
      .rdDone     (rdDone),
      .errorValid (errorValid),
      .errorInfo  (errorInfo)
   );

   // completion once both sides finish, held
   always_ff @(posedge Clk_400 or negedge rstN)
   begin
      if (!rstN)
         testCmp <= 1'b0;
      else
         testCmp <= wrDone && rdDone;
   end

endmodule

//--- tbPingPong.sv
// ping pong test bench
`timescale 1ns/100ps

module tbPingPong;
   import pingPongPkg::*;

   // **************************************************
   // run lengths and host constants
   // **************************************************
   localparam int totalLines    = 8 + 5 + 5 + 0 + 6;   // lines over all runs
   localparam int timeoutCycles = 200 + 40 * totalLines;
   localparam logic [15:0] rspHdr      = 16'h0010;   // header on read data
   localparam logic [15:0] corruptMask = 16'h5a00;   // flips low data bits

   logic        Clk_400;
   logic        rstN      = 1'b0;
   testCfg_t    cfg       = '0;
   wrReq_t      wrReq;
   logic        wrSent    = 1'b0;
   rdReq_t      rdReq;
   logic        rdSent    = 1'b0;
   rdRsp_t      rdRsp;
   rdRsp_t      rspLine   = '0;    // read data from host model
   logic [15:0] msgHdr    = '0;    // message header from stimulus
   logic        uMsgValid = 1'b0;
   logic        csrWrite  = 1'b0;
   logic        testCmp;
   logic        errorValid;
   errInfo_t    errorInfo;

   // host model state
   logic [lineBits-1:0] hostMem [0:15];
   logic [lineBits-1:0] rspData;
   logic [31:0]         hostRand = 32'd75;   // lcg seed
   logic [1:0]          wrDelay  = 2'd0;
   logic [1:0]          rdDelay  = 2'd0;
   int                  pendAddr [$];        // reads waiting for data
   int                  pick;
   int                  rspAddr;
   int                  pollAnswers = 0;
   int                  payloadRsps = 0;     // payload lines answered so far
   int                  badRspIndex = 0;     // answers sent before the bad line
   logic                flagPolled  = 1'b0;

   // scoreboard
   int       nLines;
   int       badLine       = -1;
   logic     msgSent       = 1'b0;
   logic     notified;
   int       payloadWrites = 0;
   int       payloadReads  = 0;
   logic     fenceSeen     = 1'b0;
   logic     flagSeen      = 1'b0;
   logic     errSeen       = 1'b0;
   errInfo_t errCapture    = '0;
   int       cycleCount    = 0;

   assign nLines   = int'(cfg.numLines);
   assign notified = msgSent || flagPolled;

   // message header rides on the response bus
   always_comb
   begin
      rdRsp = rspLine;
      if (uMsgValid)
      begin
         rdRsp.valid = 1'b0;
         rdRsp.hdr   = msgHdr;
      end
   end

   pingPongTest uut (
      .Clk_400    (Clk_400),
      .rstN       (rstN),
      .cfg        (cfg),
      .wrReq      (wrReq),
      .wrSent     (wrSent),
      .rdReq      (rdReq),
      .rdSent     (rdSent),
      .rdRsp      (rdRsp),
      .uMsgValid  (uMsgValid),
      .csrWrite   (csrWrite),
      .testCmp    (testCmp),
      .errorValid (errorValid),
      .errorInfo  (errorInfo)
   );

   initial
   begin
      Clk_400 = 1'b0;
      forever #50 Clk_400 = ~Clk_400;   // 100 ns period
   end

   function automatic logic [31:0] lcgNext(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // payload has every word 1 and the address in bits 16:0
   function automatic logic [lineBits-1:0] expectedLine(input int addr, input bit isFlag);
      logic [lineBits-1:0] line;
      line = '0;
      if (isFlag)
         line[63:0] = '1;
      else
      begin
         for (int w = 0; w < lineBits / 32; w++)
            line[w*32 +: 32] = 32'd1;
         line[16:0] = addr[16:0];
      end
      return line;
   endfunction

   task automatic compareValue(input string what, input logic [lineBits-1:0] got,
                               input logic [lineBits-1:0] exp);
      if (got !== exp)
      begin
         $display("Error at %0t ns: %s mismatch, got %0h expected %0h", $time, what, got, exp);
         $display("Simulation finished: FAIL");
         $fatal(1, "stopped at first error");
      end
   endtask

   // **************************************************
   // host memory model
   // **************************************************
   always @(posedge Clk_400)
   begin
      if (!rstN)
      begin
         wrSent      <= 1'b0;
         rdSent      <= 1'b0;
         rspLine     <= '0;
         wrDelay     <= 2'd1;
         rdDelay     <= 2'd1;
         pollAnswers <= 0;
         payloadRsps <= 0;
         badRspIndex <= 0;
         flagPolled  <= 1'b0;
         pendAddr.delete();
         foreach (hostMem[i])
            hostMem[i] <= '0;
      end
      else
      begin
         hostRand <= lcgNext(hostRand);
         if (wrSent)   // request taken at this edge
         begin
            wrSent  <= 1'b0;
            wrDelay <= hostRand[17:16];
            if (wrReq.en)
               hostMem[wrReq.addr[3:0]] <= wrReq.data;
         end
         else if (wrReq.en || wrReq.fence)
         begin
            if (wrDelay == 2'd0)
               wrSent <= 1'b1;
            else
               wrDelay <= wrDelay - 2'd1;   // back-pressure
         end

         // answer before taking new reads so latency is at least one
         rspLine.valid <= 1'b0;
         if (pendAddr.size() > 0 && hostRand[25:24] != 2'd0)
         begin
            pick    = (pendAddr.size() > 1 && hostRand[26]) ? pendAddr.size() - 1 : 0;
            rspAddr = pendAddr[pick];
            pendAddr.delete(pick);   // younger one may go first
            rspData = hostMem[rspAddr[3:0]];
            if (rspAddr == nLines)
            begin
               if (pollAnswers == 0)
                  rspData = '0;        // host has not seen the flag yet
               else
                  flagPolled <= 1'b1;
               pollAnswers <= pollAnswers + 1;
            end
            else
            begin
               if (rspAddr == badLine)
               begin
                  rspData[15:0] = rspData[15:0] ^ corruptMask;
                  badRspIndex   <= payloadRsps;
               end
               payloadRsps <= payloadRsps + 1;
            end
            rspLine <= '{valid: 1'b1, hdr: rspHdr, addr: addrBits'(rspAddr), data: rspData};
         end

         if (rdSent)
         begin
            rdSent  <= 1'b0;
            rdDelay <= hostRand[21:20];
            pendAddr.push_back(int'(rdReq.addr));
         end
         else if (rdReq.en)
         begin
            if (rdDelay == 2'd0)
               rdSent <= 1'b1;
            else
               rdDelay <= rdDelay - 2'd1;
         end
      end
   end

   // **************************************************
   // compare process
   // **************************************************
   always @(posedge Clk_400)
   begin
      if (!rstN)
      begin
         payloadWrites <= 0;
         payloadReads  <= 0;
         fenceSeen     <= 1'b0;
         flagSeen      <= 1'b0;
         errSeen       <= 1'b0;
      end
      else
      begin
         if (wrSent && wrReq.fence)
         begin
            compareValue("writes before fence", lineBits'(payloadWrites), lineBits'(nLines));
            fenceSeen <= 1'b1;
         end
         else if (wrSent && wrReq.en && int'(wrReq.addr) == nLines)
         begin
            compareValue("fence before flag", lineBits'(fenceSeen), lineBits'(nLines != 0));
            compareValue("flag tag", lineBits'(wrReq.tag), lineBits'({1'b0, 15'(nLines)}));
            compareValue("flag line", wrReq.data, expectedLine(nLines, 1'b1));
            flagSeen <= 1'b1;
         end
         else if (wrSent && wrReq.en)
         begin
            compareValue("write address", lineBits'(wrReq.addr), lineBits'(payloadWrites));
            compareValue("write tag", lineBits'(wrReq.tag),
                         lineBits'({1'b0, 15'(payloadWrites)}));
            compareValue("payload line", wrReq.data, expectedLine(int'(wrReq.addr), 1'b0));
            payloadWrites <= payloadWrites + 1;
         end

         // payload reads only once the host has notified
         if (rdReq.en && int'(rdReq.addr) != nLines)
            compareValue("read before notification", lineBits'(notified), lineBits'(1'b1));
         if (rdSent && rdReq.en && int'(rdReq.addr) != nLines)
         begin
            compareValue("read address", lineBits'(rdReq.addr), lineBits'(payloadReads));
            compareValue("read tag", lineBits'(rdReq.tag),
                         lineBits'({1'b1, 15'(payloadReads)}));
            payloadReads <= payloadReads + 1;
         end

         if (errorValid && !errSeen)
         begin
            errSeen    <= 1'b1;
            errCapture <= errorInfo;   // info of the first bad line
         end
      end
   end

   // timeout
   always @(posedge Clk_400)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= timeoutCycles)
      begin
         $display("Timeout: the test did not complete in time (%0d cycles)", cycleCount);
         $display("Simulation finished: FAIL");
         $fatal(1, "timeout");
      end
   end

   // **************************************************
   // stimulus
   // **************************************************
   task automatic sendMessage(input logic [15:0] hdr, input bit good);
      @(posedge Clk_400);
      uMsgValid <= 1'b1;
      msgHdr    <= hdr;
      if (good)
         msgSent <= 1'b1;
      @(posedge Clk_400);
      uMsgValid <= 1'b0;
      repeat (5) @(posedge Clk_400);   // room for a wrong start to show
   endtask

   task automatic pulseCsr;
      @(posedge Clk_400);
      csrWrite <= 1'b1;
      msgSent  <= 1'b1;
      @(posedge Clk_400);
      csrWrite <= 1'b0;
   endtask

   task automatic verifyTotals(input notifyMode_t mode, input int n, input int bad);
      logic [lineBits-1:0] badExp;
      compareValue("payload writes", lineBits'(payloadWrites), lineBits'(n));
      compareValue("fence written", lineBits'(fenceSeen), lineBits'(n != 0));
      compareValue("payload reads taken", lineBits'(payloadReads), lineBits'(n));
      compareValue("errorValid", lineBits'(errSeen), lineBits'(bad >= 0));
      if (mode == MODE_POLL)
         compareValue("poll reads answered", lineBits'(pollAnswers), lineBits'(2));
      if (bad >= 0)
      begin
         badExp = expectedLine(bad, 1'b0);
         compareValue("errorInfo data16", lineBits'(errCapture.data16),
                      lineBits'(badExp[15:0] ^ corruptMask));
         compareValue("errorInfo addr16", lineBits'(errCapture.addr16), lineBits'(bad));
         compareValue("errorInfo hdr16", lineBits'(errCapture.hdr16), lineBits'(rspHdr));
         compareValue("errorInfo count", lineBits'(errCapture.count), lineBits'(badRspIndex));
      end
   endtask

   task automatic runTest(input notifyMode_t mode, input int n, input int bad);
      @(posedge Clk_400);
      rstN    <= 1'b0;
      cfg     <= '{go: 1'b0, numLines: 32'(n), mode: mode};
      badLine <= bad;
      msgSent <= 1'b0;
      repeat (4) @(posedge Clk_400);
      rstN <= 1'b1;
      @(posedge Clk_400);
      cfg.go <= 1'b1;   // one-cycle start
      @(posedge Clk_400);
      cfg.go <= 1'b0;
      while (!flagSeen)
         @(posedge Clk_400);
      case (mode)
         MODE_CSR:
         begin
            repeat (5) @(posedge Clk_400);
            pulseCsr();
         end
         MODE_UMSG_DATA:
         begin
            sendMessage(16'h0001, 1'b0);   // wrong id
            sendMessage(16'h8000, 1'b0);   // hint instead of data
            sendMessage(16'h0000, 1'b1);
         end
         MODE_UMSG_HINT:
            sendMessage(16'h8000, 1'b1);
         default:
            ;   // host answers the flag reads
      endcase
      while (!testCmp)
         @(posedge Clk_400);
      repeat (4) @(posedge Clk_400);   // let the data check settle
      verifyTotals(mode, n, bad);
   endtask

   initial
   begin
      runTest(MODE_POLL, 8, -1);
      runTest(MODE_CSR, 5, -1);
      runTest(MODE_UMSG_DATA, 5, -1);
      runTest(MODE_UMSG_HINT, 0, -1);
      runTest(MODE_CSR, 6, 3);          // line 3 corrupted by host
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

//--- sources.f
pingPongPkg.sv
writeSequencer.sv
notifyDetect.sv
readSequencer.sv
pingPongTest.sv
tbPingPong.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = tbPingPong
FILELIST  = sources.f
OBJDIR    = obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(OBJDIR)
